// File: Makefile
# Verilator simulation of the MSI-X shim

VERILATOR ?= verilator
TOP       ?= tb_msix_shim
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "^SIMULATION PASSED" $(LOG) || (echo "Run failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: all.f
logic/msix_pkg.sv
logic/rx_req_splitter.sv
logic/tx_intr_splitter.sv
logic/msix_vector_table.sv
logic/tx_merge.sv
logic/msix_shim_top.sv
dv/tb_clk_gen.sv
dv/tb_msix_shim.sv

// File: dv/tb_clk_gen.sv
/* Testbench clock and reset source
   Free-running clock with a synchronous active-low reset pulse */

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release just after an edge, like the other inputs
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: dv/tb_msix_shim.sv
/* MSI-X shim testbench
   Applies a table of host and function packets and checks what leaves the shim */

`timescale 1ns/1ps
`default_nettype none

module tb_msix_shim;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 4;
    localparam int TABLE_SIZE    = 8;
    localparam int ROW_CYCLES    = 60;
    localparam int ROW_TIMEOUT   = 40;
    localparam int QUIET_CYCLES  = 8;

    // What a row should produce
    localparam int E_NONE   = 0;
    localparam int E_RX     = 1;
    localparam int E_TX     = 2;
    localparam int E_MSG    = 3;
    // Function packet on tx_out, then the completion of a host read sent beside it
    localparam int E_TX_CPL = 4;

    typedef struct {
        bit                          src_tx;
        logic [63:0]                 hdr;
        logic [63:0]                 payload;
        int                          nbeats;
        logic [msix_pkg::BEAT_W-1:0] tail;
        int                          exp_kind;
        logic [63:0]                 exp_hdr;
        logic [63:0]                 exp_data;
    } row_t;

    logic                        clk;
    logic                        rst_n;
    logic                        rx_in_valid;
    logic                        rx_in_ready;
    logic [msix_pkg::BEAT_W-1:0] rx_in_data;
    logic                        rx_in_last;
    logic                        rx_out_valid;
    logic                        rx_out_ready;
    logic [msix_pkg::BEAT_W-1:0] rx_out_data;
    logic                        rx_out_last;
    logic                        tx_in_valid;
    logic                        tx_in_ready;
    logic [msix_pkg::BEAT_W-1:0] tx_in_data;
    logic                        tx_in_last;
    logic                        tx_out_valid;
    logic                        tx_out_ready;
    logic [msix_pkg::BEAT_W-1:0] tx_out_data;
    logic                        tx_out_last;

    row_t                      rows[$];
    logic [msix_pkg::BEAT_W:0] rx_q[$];
    logic [msix_pkg::BEAT_W:0] tx_q[$];
    int                        errors = 0;
    bit                        rows_loaded = 1'b0;

    tb_clk_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) tb_clk_gen_i (
        .clk, .rst_n
    );

    msix_shim_top #(
        .TABLE_SIZE    (TABLE_SIZE),
        .TABLE_OFFSET  (32'h2000),
        .MSIX_BAR      (0),
        .BAR_LOG2_SIZE (14)
    ) msix_shim_top_i (
        .clk, .rst_n,
        .rx_in_valid, .rx_in_ready, .rx_in_data, .rx_in_last,
        .rx_out_valid, .rx_out_ready, .rx_out_data, .rx_out_last,
        .tx_in_valid, .tx_in_ready, .tx_in_data, .tx_in_last,
        .tx_out_valid, .tx_out_ready, .tx_out_data, .tx_out_last
    );

    // ====================
    // Helpers
    // ====================

    // Field order kind, bar, length, tag, address from the most significant end
    function automatic logic [63:0] req_hdr(input logic [7:0] kind, input logic [3:0] bar,
                                            input logic [3:0] len, input logic [7:0] tag,
                                            input logic [39:0] addr);
        return {kind, bar, len, tag, addr};
    endfunction

    function automatic logic [63:0] intr_hdr(input logic [15:0] vec);
        return {msix_pkg::KIND_INTR, vec, 40'h0};
    endfunction

    task automatic add_row(input bit src_tx, input logic [63:0] hdr, input logic [63:0] payload,
                           input int nbeats, input logic [msix_pkg::BEAT_W-1:0] tail,
                           input int exp_kind, input logic [63:0] exp_hdr,
                           input logic [63:0] exp_data);
        row_t r;
        r.src_tx   = src_tx;
        r.hdr      = hdr;
        r.payload  = payload;
        r.nbeats   = nbeats;
        r.tail     = tail;
        r.exp_kind = exp_kind;
        r.exp_hdr  = exp_hdr;
        r.exp_data = exp_data;
        rows.push_back(r);
    endtask

    // Beat b as it should leave the shim, last flag on top
    function automatic logic [msix_pkg::BEAT_W:0] expected_beat(input row_t r, input int b);
        if (r.exp_kind == E_MSG || (r.exp_kind == E_TX_CPL && b == r.nbeats)) begin
            return {1'b1, r.exp_data, r.exp_hdr};
        end
        if (b == 0) begin
            return {r.nbeats == 1, r.payload, r.hdr};
        end
        return {b == r.nbeats - 1, r.tail};
    endfunction

    // Entered just after a rising edge, returns just after the transfer edge
    task automatic drive_beat(input bit src_tx, input logic [msix_pkg::BEAT_W-1:0] data,
                              input logic last);
        if (src_tx) begin
            tx_in_valid = 1'b1;
            tx_in_data  = data;
            tx_in_last  = last;
        end else begin
            rx_in_valid = 1'b1;
            rx_in_data  = data;
            rx_in_last  = last;
        end
        @(negedge clk);
        while (!(src_tx ? tx_in_ready : rx_in_ready)) @(negedge clk);
        @(posedge clk);
        #2;
    endtask

    task automatic drive_packet(input row_t r);
        drive_beat(r.src_tx, {r.payload, r.hdr}, r.nbeats == 1);
        for (int b = 1; b < r.nbeats; b++) begin
            drive_beat(r.src_tx, r.tail, b == r.nbeats - 1);
        end
    endtask

    // Host read sent once the first function beat has left, so its completion
    // is ready while the rest of the function packet is still going out.
    // The request carries the length, tag and address that the completion echoes
    task automatic read_during_packet(input logic [63:0] cpl_hdr);
        @(negedge clk);
        while (!(tx_out_valid && tx_out_ready)) @(negedge clk);
        @(posedge clk);
        #2;
        drive_beat(1'b0, {64'h0, msix_pkg::KIND_MRD, 4'h0, cpl_hdr[51:0]}, 1'b1);
        rx_in_valid = 1'b0;
    endtask

    task automatic run_row(input int idx, input row_t r);
        int                        n_exp;
        int                        exp_rx;
        int                        exp_tx;
        int                        waited;
        logic [msix_pkg::BEAT_W:0] got;
        logic [msix_pkg::BEAT_W:0] want;
        n_exp  = (r.exp_kind == E_NONE) ? 0 :
                 (r.exp_kind == E_MSG) ? 1 :
                 (r.exp_kind == E_TX_CPL) ? r.nbeats + 1 : r.nbeats;
        exp_rx = (r.exp_kind == E_RX) ? n_exp : 0;
        exp_tx = (r.exp_kind == E_TX || r.exp_kind == E_MSG || r.exp_kind == E_TX_CPL) ?
                 n_exp : 0;
        @(posedge clk);
        #2;
        if (r.exp_kind == E_TX_CPL) begin
            fork
                drive_packet(r);
                read_during_packet(r.exp_hdr);
            join
        end else begin
            drive_packet(r);
        end
        rx_in_valid = 1'b0;
        tx_in_valid = 1'b0;
        waited = 0;
        while ((rx_q.size() < exp_rx || tx_q.size() < exp_tx) && waited < ROW_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        // Extra beats would show up here
        repeat (QUIET_CYCLES) @(negedge clk);
        if (rx_q.size() != exp_rx || tx_q.size() != exp_tx) begin
            errors++;
            $display("** Error at %0t: row %0d wants %0d rx_out, %0d tx_out beats, saw %0d, %0d",
                     $time, idx, exp_rx, exp_tx, rx_q.size(), tx_q.size());
        end else begin
            for (int b = 0; b < n_exp; b++) begin
                got  = (exp_rx != 0) ? rx_q[b] : tx_q[b];
                want = expected_beat(r, b);
                if (got !== want) begin
                    errors++;
                    $display("** Error at %0t: row %0d beat %0d got %h expected %h",
                             $time, idx, b, got, want);
                end
            end
        end
        rx_q.delete();
        tx_q.delete();
    endtask

    // ====================
    // Output monitors and back-pressure
    // ====================
    always @(negedge clk) begin
        if (rst_n && rx_out_valid && rx_out_ready) begin
            rx_q.push_back({rx_out_last, rx_out_data});
        end
        if (rst_n && tx_out_valid && tx_out_ready) begin
            tx_q.push_back({tx_out_last, tx_out_data});
        end
    end

    initial begin
        tx_out_ready = 1'b1;
        void'($urandom(97));
        forever begin
            @(posedge clk);
            #2;
            tx_out_ready = ($urandom % 4) != 0;
        end
    end

    initial begin
        wait (rows_loaded);
        #((rows.size() * ROW_CYCLES + TABLE_SIZE + RESET_CYCLES) * CLK_PERIOD);
        $display("Watchdog timeout: the rows did not finish in the allowed time");
        $display("SIMULATION FAILED");
        $finish;
    end

    // ====================
    // Stimulus table and main loop
    // ====================
    initial begin
        rx_in_valid  = 1'b0;
        rx_in_data   = '0;
        rx_in_last   = 1'b0;
        rx_out_ready = 1'b1;
        tx_in_valid  = 1'b0;
        tx_in_data   = '0;
        tx_in_last   = 1'b0;

        // Outside the table: other BAR, below, past the end, table-like second beat
        add_row(0, req_hdr(msix_pkg::KIND_MWR, 4'h1, 4'd1, 8'h01, 40'h2000),
                64'h0000_0000_1111_2222, 1, '0, E_RX, '0, '0);
        add_row(0, req_hdr(msix_pkg::KIND_MRD, 4'h0, 4'd1, 8'h02, 40'h1ffc),
                '0, 1, '0, E_RX, '0, '0);
        add_row(0, req_hdr(msix_pkg::KIND_MRD, 4'h0, 4'd1, 8'h03, 40'h2080),
                '0, 1, '0, E_RX, '0, '0);
        add_row(0, req_hdr(msix_pkg::KIND_MWR, 4'h2, 4'd4, 8'h04, 40'h0100),
                64'ha5a5_a5a5_5a5a_5a5a, 2,
                {64'h0123_4567_89ab_cdef,
                 req_hdr(msix_pkg::KIND_MRD, 4'h0, 4'd1, 8'h05, 40'h2000)},
                E_RX, '0, '0);

        // Entry 1 written, then read back; last read aliases above the BAR size
        add_row(0, req_hdr(msix_pkg::KIND_MWR, 4'h0, 4'd2, 8'h06, 40'h2010),
                64'h0000_00ab_fee0_0010, 1, '0, E_NONE, '0, '0);
        add_row(0, req_hdr(msix_pkg::KIND_MWR, 4'h0, 4'd1, 8'h07, 40'h2018),
                64'h0000_0000_0000_1234, 1, '0, E_NONE, '0, '0);
        add_row(0, req_hdr(msix_pkg::KIND_MRD, 4'h0, 4'd2, 8'h11, 40'h2010), '0, 1, '0, E_MSG,
                req_hdr(msix_pkg::KIND_CPL, msix_pkg::CPL_OK, 4'd2, 8'h11, 40'h2010),
                64'h0000_00ab_fee0_0010);
        add_row(0, req_hdr(msix_pkg::KIND_MRD, 4'h0, 4'd1, 8'h12, 40'h2018), '0, 1, '0, E_MSG,
                req_hdr(msix_pkg::KIND_CPL, msix_pkg::CPL_OK, 4'd1, 8'h12, 40'h2018),
                64'h0000_0000_0000_1234);
        add_row(0, req_hdr(msix_pkg::KIND_MRD, 4'h0, 4'd1, 8'h13, 40'h6018), '0, 1, '0, E_MSG,
                req_hdr(msix_pkg::KIND_CPL, msix_pkg::CPL_OK, 4'd1, 8'h13, 40'h6018),
                64'h0000_0000_0000_1234);

        // Interrupts: live vector, then masked, out of range, function packets, cleared entry
        add_row(1, intr_hdr(16'd1), '0, 1, '0, E_MSG,
                req_hdr(msix_pkg::KIND_MWR, 4'h0, 4'd1, 8'h00, 40'hab_fee0_0010),
                64'h0000_0000_0000_1234);
        add_row(0, req_hdr(msix_pkg::KIND_MWR, 4'h0, 4'd1, 8'h08, 40'h201c),
                64'h0000_0000_0000_0001, 1, '0, E_NONE, '0, '0);
        add_row(1, intr_hdr(16'd1), '0, 1, '0, E_NONE, '0, '0);
        // Low bits select entry 2, which is live
        add_row(1, intr_hdr(16'd10), '0, 1, '0, E_NONE, '0, '0);
        add_row(1, req_hdr(msix_pkg::KIND_MWR, 4'h0, 4'd4, 8'h30, 40'h1000),
                64'hcafe_f00d_0bad_beef, 2, {64'h5555_6666_7777_8888, intr_hdr(16'd0)},
                E_TX, '0, '0);
        add_row(1, req_hdr(msix_pkg::KIND_MWR, 4'h0, 4'd6, 8'h31, 40'h1800),
                64'h1357_9bdf_2468_ace0, 3, {64'h0f0f_0f0f_f0f0_f0f0, 64'h3c3c_3c3c_c3c3_c3c3},
                E_TX_CPL, req_hdr(msix_pkg::KIND_CPL, msix_pkg::CPL_OK, 4'd1, 8'h32, 40'h2018),
                64'h0000_0000_0000_1234);
        add_row(1, intr_hdr(16'd0), '0, 1, '0, E_MSG,
                req_hdr(msix_pkg::KIND_MWR, 4'h0, 4'd1, 8'h00, 40'h0), '0);

        // Unsupported forms, then read-back shows the writes were ignored
        add_row(0, req_hdr(msix_pkg::KIND_MRD, 4'h0, 4'd3, 8'h21, 40'h2010), '0, 1, '0, E_MSG,
                req_hdr(msix_pkg::KIND_CPL, msix_pkg::CPL_UNSUPPORTED, 4'd3, 8'h21, 40'h2010), '0);
        add_row(0, req_hdr(msix_pkg::KIND_MRD, 4'h0, 4'd2, 8'h22, 40'h2014), '0, 1, '0, E_MSG,
                req_hdr(msix_pkg::KIND_CPL, msix_pkg::CPL_UNSUPPORTED, 4'd2, 8'h22, 40'h2014), '0);
        add_row(0, req_hdr(msix_pkg::KIND_MWR, 4'h0, 4'd2, 8'h09, 40'h2014),
                64'hdead_0001_beef_0002, 1, '0, E_NONE, '0, '0);
        add_row(0, req_hdr(msix_pkg::KIND_MWR, 4'h0, 4'd3, 8'h0a, 40'h2010),
                64'h1111_2222_3333_4444, 1, '0, E_NONE, '0, '0);
        add_row(0, req_hdr(msix_pkg::KIND_MRD, 4'h0, 4'd2, 8'h23, 40'h2010), '0, 1, '0, E_MSG,
                req_hdr(msix_pkg::KIND_CPL, msix_pkg::CPL_OK, 4'd2, 8'h23, 40'h2010),
                64'h0000_00ab_fee0_0010);
        add_row(0, req_hdr(msix_pkg::KIND_MRD, 4'h0, 4'd2, 8'h24, 40'h2018), '0, 1, '0, E_MSG,
                req_hdr(msix_pkg::KIND_CPL, msix_pkg::CPL_OK, 4'd2, 8'h24, 40'h2018),
                64'h0000_0001_0000_1234);
        rows_loaded = 1'b1;

        wait (rst_n);
        for (int i = 0; i < rows.size(); i++) begin
            run_row(i, rows[i]);
        end

        $display("Rows run: %0d, errors: %0d", rows.size(), errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/msix_pkg.sv
/* MSI-X shim shared definitions
   Beat widths, header kinds, header layouts and completion status codes */

`default_nettype none

package msix_pkg;

    // ====================
    // Widths
    // ====================
    localparam int HDR_W  = 64;
    localparam int DATA_W = 64;
    localparam int BEAT_W = HDR_W + DATA_W;

    // ====================
    // Header kinds
    // ====================
    typedef enum logic [7:0] {
        KIND_MRD  = 8'h00,
        KIND_MWR  = 8'h40,
        KIND_CPL  = 8'h4a,
        KIND_INTR = 8'h30
    } kind_t;

    // Completion status, carried in the bar field of a completion
    localparam logic [3:0] CPL_OK          = 4'h0;
    localparam logic [3:0] CPL_UNSUPPORTED = 4'h1;

    // ====================
    // Header layouts
    // ====================

    // Memory request or completion header
    typedef struct packed {
        kind_t       kind;
        logic [3:0]  bar;
        logic [3:0]  length;
        logic [7:0]  tag;
        logic [39:0] addr;
    } req_hdr_t;

    // Interrupt request from the function
    typedef struct packed {
        kind_t       kind;
        logic [15:0] vector;
        logic [39:0] rsvd;
    } intr_hdr_t;

    // Transmit header word, read either way
    typedef union packed {
        req_hdr_t  req;
        intr_hdr_t intr;
    } hdr_word_u;

endpackage

`default_nettype wire

// File: logic/msix_shim_top.sv
/* MSI-X shim top level
   Splits table traffic and interrupts off the streams and merges the replies */

`timescale 1ns/1ps
`default_nettype none

module msix_shim_top #(
    parameter int TABLE_SIZE    = 8,
    parameter int TABLE_OFFSET  = 32'h2000,
    parameter int MSIX_BAR      = 0,
    parameter int BAR_LOG2_SIZE = 14
) (
    input  logic                        clk,
    input  logic                        rst_n,

    // Host requests in
    input  logic                        rx_in_valid,
    output logic                        rx_in_ready,
    input  logic [msix_pkg::BEAT_W-1:0] rx_in_data,
    input  logic                        rx_in_last,

    // Host requests toward the function
    output logic                        rx_out_valid,
    input  logic                        rx_out_ready,
    output logic [msix_pkg::BEAT_W-1:0] rx_out_data,
    output logic                        rx_out_last,

    // Function transmit in
    input  logic                        tx_in_valid,
    output logic                        tx_in_ready,
    input  logic [msix_pkg::BEAT_W-1:0] tx_in_data,
    input  logic                        tx_in_last,

    // Transmit toward the host
    output logic                        tx_out_valid,
    input  logic                        tx_out_ready,
    output logic [msix_pkg::BEAT_W-1:0] tx_out_data,
    output logic                        tx_out_last
);

    // Table access path
    logic                        acc_valid;
    logic                        acc_ready;
    msix_pkg::req_hdr_t          acc_hdr;
    logic [msix_pkg::DATA_W-1:0] acc_data;

    // Function pass-through path
    logic                        pass_valid;
    logic                        pass_ready;
    logic [msix_pkg::BEAT_W-1:0] pass_data;
    logic                        pass_last;

    // Interrupt requests
    logic                        intr_valid;
    logic                        intr_ready;
    logic [15:0]                 intr_vector;

    // Completions and interrupt writes from the table
    logic                        msg_valid;
    logic                        msg_ready;
    msix_pkg::req_hdr_t          msg_hdr;
    logic [msix_pkg::DATA_W-1:0] msg_data;

    rx_req_splitter #(
        .TABLE_SIZE    (TABLE_SIZE),
        .TABLE_OFFSET  (TABLE_OFFSET),
        .MSIX_BAR      (MSIX_BAR),
        .BAR_LOG2_SIZE (BAR_LOG2_SIZE)
    ) rx_req_splitter_i (
        .clk, .rst_n,
        .rx_in_valid, .rx_in_ready, .rx_in_data, .rx_in_last,
        .rx_out_valid, .rx_out_ready, .rx_out_data, .rx_out_last,
        .acc_valid, .acc_hdr, .acc_data, .acc_ready
    );

    tx_intr_splitter tx_intr_splitter_i (
        .clk, .rst_n,
        .tx_in_valid, .tx_in_ready, .tx_in_data, .tx_in_last,
        .pass_valid, .pass_ready, .pass_data, .pass_last,
        .intr_valid, .intr_ready, .intr_vector
    );

    msix_vector_table #(
        .TABLE_SIZE    (TABLE_SIZE),
        .TABLE_OFFSET  (TABLE_OFFSET),
        .BAR_LOG2_SIZE (BAR_LOG2_SIZE)
    ) msix_vector_table_i (
        .clk, .rst_n,
        .acc_valid, .acc_ready, .acc_hdr, .acc_data,
        .intr_valid, .intr_ready, .intr_vector,
        .msg_valid, .msg_ready, .msg_hdr, .msg_data
    );

    tx_merge tx_merge_i (
        .clk, .rst_n,
        .pass_valid, .pass_ready, .pass_data, .pass_last,
        .msg_valid, .msg_ready, .msg_hdr, .msg_data,
        .tx_out_valid, .tx_out_ready, .tx_out_data, .tx_out_last
    );

endmodule

`default_nettype wire

// File: logic/msix_vector_table.sv
/* MSI-X vector table
   Holds the entries, answers host reads and turns interrupts into writes */

`timescale 1ns/1ps
`default_nettype none

module msix_vector_table #(
    parameter int TABLE_SIZE    = 8,
    parameter int TABLE_OFFSET  = 32'h2000,
    parameter int BAR_LOG2_SIZE = 14
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        acc_valid,
    output logic                        acc_ready,
    input  msix_pkg::req_hdr_t          acc_hdr,
    input  logic [msix_pkg::DATA_W-1:0] acc_data,
    input  logic                        intr_valid,
    output logic                        intr_ready,
    input  logic [15:0]                 intr_vector,
    output logic                        msg_valid,
    input  logic                        msg_ready,
    output msix_pkg::req_hdr_t          msg_hdr,
    output logic [msix_pkg::DATA_W-1:0] msg_data
);

    localparam int IDX_W      = (TABLE_SIZE > 1) ? $clog2(TABLE_SIZE) : 1;
    localparam int START_LINE = TABLE_OFFSET / 16;

    // Dwords per entry: addr low, addr high, data, control
    logic [3:0][31:0] tbl [TABLE_SIZE];

    logic [IDX_W-1:0]         clr_idx;
    logic                     tbl_ready;
    logic [BAR_LOG2_SIZE-5:0] acc_line;
    logic [IDX_W-1:0]         acc_idx;
    logic [1:0]               acc_dw;
    logic                     acc_form_ok;
    logic                     acc_is_wr;
    logic                     acc_two;
    logic                     slot_free;
    logic                     wr_fire;
    logic                     rd_fire;
    logic                     intr_fire;
    logic [IDX_W-1:0]         intr_idx;
    logic                     intr_hit;
    logic [31:0]              rd_lo;
    logic [31:0]              rd_hi;

    // ====================
    // Clear after reset
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clr_idx   <= '0;
            tbl_ready <= 1'b0;
        end else if (!tbl_ready) begin
            if (clr_idx == IDX_W'(TABLE_SIZE - 1)) begin
                tbl_ready <= 1'b1;
            end else begin
                clr_idx <= clr_idx + 1'b1;
            end
        end
    end

    // ====================
    // Access decode
    // ====================
    assign acc_line    = acc_hdr.addr[BAR_LOG2_SIZE-1:4];
    assign acc_idx     = IDX_W'(32'(acc_line) - START_LINE);
    assign acc_dw      = acc_hdr.addr[3:2];
    assign acc_two     = (acc_hdr.length == 4'd2);
    // Single dword anywhere, or an aligned dword pair
    assign acc_form_ok = (acc_hdr.length == 4'd1) || (acc_two && !acc_dw[0]);
    assign acc_is_wr   = (acc_hdr.kind == msix_pkg::KIND_MWR);

    // Slot takes a new message when empty or draining this cycle
    assign slot_free  = !msg_valid || msg_ready;
    assign acc_ready  = tbl_ready && (acc_is_wr || slot_free);
    assign intr_ready = tbl_ready && slot_free && !acc_valid;

    assign wr_fire   = acc_valid && acc_ready && acc_is_wr && acc_form_ok;
    assign rd_fire   = acc_valid && acc_ready && !acc_is_wr;
    assign intr_fire = intr_valid && intr_ready;

    assign intr_idx = intr_vector[IDX_W-1:0];
    assign intr_hit = (32'(intr_vector) < TABLE_SIZE) && !tbl[intr_idx][3][0];

    assign rd_lo = tbl[acc_idx][acc_dw];
    assign rd_hi = acc_two ? tbl[acc_idx][acc_dw | 2'd1] : 32'h0;

    // Entry storage
    always_ff @(posedge clk) begin
        if (!tbl_ready) begin
            tbl[clr_idx] <= '0;
        end else if (wr_fire) begin
            tbl[acc_idx][acc_dw] <= acc_data[31:0];
            if (acc_two) begin
                tbl[acc_idx][acc_dw | 2'd1] <= acc_data[63:32];
            end
        end
    end

    // ====================
    // Message slot
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            msg_valid <= 1'b0;
        end else if (rd_fire || (intr_fire && intr_hit)) begin
            msg_valid <= 1'b1;
        end else if (msg_ready) begin
            msg_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            msg_hdr.kind   <= msix_pkg::KIND_CPL;
            msg_hdr.bar    <= acc_form_ok ? msix_pkg::CPL_OK : msix_pkg::CPL_UNSUPPORTED;
            msg_hdr.length <= acc_hdr.length;
            msg_hdr.tag    <= acc_hdr.tag;
            msg_hdr.addr   <= acc_hdr.addr;
            msg_data       <= acc_form_ok ? {rd_hi, rd_lo} : '0;
        end else if (intr_fire && intr_hit) begin
            msg_hdr.kind   <= msix_pkg::KIND_MWR;
            msg_hdr.bar    <= 4'h0;
            msg_hdr.length <= 4'd1;
            msg_hdr.tag    <= 8'h0;
            // 40-bit message address from the high and low dwords
            msg_hdr.addr   <= {tbl[intr_idx][1][7:0], tbl[intr_idx][0]};
            msg_data       <= {32'h0, tbl[intr_idx][2]};
        end
    end

    a_msg_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (msg_valid && !msg_ready) |=> (msg_valid && $stable(msg_hdr)));

endmodule

`default_nettype wire

// File: logic/rx_req_splitter.sv
/* Host request splitter
   Routes memory requests that hit the MSI-X table window to the table */

`timescale 1ns/1ps
`default_nettype none

module rx_req_splitter #(
    parameter int TABLE_SIZE    = 8,
    parameter int TABLE_OFFSET  = 32'h2000,
    parameter int MSIX_BAR      = 0,
    parameter int BAR_LOG2_SIZE = 14
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        rx_in_valid,
    output logic                        rx_in_ready,
    input  logic [msix_pkg::BEAT_W-1:0] rx_in_data,
    input  logic                        rx_in_last,
    output logic                        rx_out_valid,
    input  logic                        rx_out_ready,
    output logic [msix_pkg::BEAT_W-1:0] rx_out_data,
    output logic                        rx_out_last,
    output logic                        acc_valid,
    output msix_pkg::req_hdr_t          acc_hdr,
    output logic [msix_pkg::DATA_W-1:0] acc_data,
    input  logic                        acc_ready
);

    // Table window in 16-byte lines of the BAR
    localparam int START_LINE = TABLE_OFFSET / 16;
    localparam int END_LINE   = START_LINE + TABLE_SIZE;

    logic                     sop;
    msix_pkg::req_hdr_t       hdr;
    logic [BAR_LOG2_SIZE-5:0] addr_line;
    logic                     is_mem_req;
    logic                     is_table;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sop <= 1'b1;
        end else if (rx_in_valid && rx_in_ready) begin
            sop <= rx_in_last;
        end
    end

    assign hdr = msix_pkg::req_hdr_t'(rx_in_data[msix_pkg::HDR_W-1:0]);

    // Upper address bits alias back into the BAR
    assign addr_line  = hdr.addr[BAR_LOG2_SIZE-1:4];
    assign is_mem_req = (hdr.kind == msix_pkg::KIND_MRD) || (hdr.kind == msix_pkg::KIND_MWR);
    assign is_table   = sop && is_mem_req && (hdr.bar == MSIX_BAR[3:0]) &&
                        (32'(addr_line) >= START_LINE) && (32'(addr_line) < END_LINE);

    assign rx_out_valid = rx_in_valid && !is_table;
    assign rx_out_data  = rx_in_data;
    assign rx_out_last  = rx_in_last;

    assign acc_valid = rx_in_valid && is_table;
    assign acc_hdr   = hdr;
    assign acc_data  = rx_in_data[msix_pkg::BEAT_W-1:msix_pkg::HDR_W];

    assign rx_in_ready = is_table ? acc_ready : rx_out_ready;

    // Table accesses are single-beat packets, a second beat would leak to rx_out
    a_acc_single: assert property (@(posedge clk) disable iff (!rst_n)
        acc_valid |-> rx_in_last);

endmodule

`default_nettype wire

// File: logic/tx_intr_splitter.sv
/* Function transmit splitter
   Pulls interrupt requests off the transmit stream and sends them to the table */

`timescale 1ns/1ps
`default_nettype none

module tx_intr_splitter (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        tx_in_valid,
    output logic                        tx_in_ready,
    input  logic [msix_pkg::BEAT_W-1:0] tx_in_data,
    input  logic                        tx_in_last,
    output logic                        pass_valid,
    input  logic                        pass_ready,
    output logic [msix_pkg::BEAT_W-1:0] pass_data,
    output logic                        pass_last,
    output logic                        intr_valid,
    input  logic                        intr_ready,
    output logic [15:0]                 intr_vector
);

    logic                sop;
    msix_pkg::hdr_word_u hdr;
    logic                is_intr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sop <= 1'b1;
        end else if (tx_in_valid && tx_in_ready) begin
            sop <= tx_in_last;
        end
    end

    // Kind is decoded in the request view, the vector in the interrupt view
    assign hdr     = tx_in_data[msix_pkg::HDR_W-1:0];
    assign is_intr = sop && (hdr.req.kind == msix_pkg::KIND_INTR);

    assign pass_valid = tx_in_valid && !is_intr;
    assign pass_data  = tx_in_data;
    assign pass_last  = tx_in_last;

    assign intr_valid  = tx_in_valid && is_intr;
    assign intr_vector = hdr.intr.vector;

    assign tx_in_ready = is_intr ? intr_ready : pass_ready;

    // Interrupt requests are single-beat packets
    a_intr_single: assert property (@(posedge clk) disable iff (!rst_n)
        intr_valid |-> tx_in_last);

endmodule

`default_nettype wire

// File: logic/tx_merge.sv
/* Transmit merge
   Packet-level arbiter between function traffic and table messages */

`timescale 1ns/1ps
`default_nettype none

module tx_merge (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        pass_valid,
    output logic                        pass_ready,
    input  logic [msix_pkg::BEAT_W-1:0] pass_data,
    input  logic                        pass_last,
    input  logic                        msg_valid,
    output logic                        msg_ready,
    input  msix_pkg::req_hdr_t          msg_hdr,
    input  logic [msix_pkg::DATA_W-1:0] msg_data,
    output logic                        tx_out_valid,
    input  logic                        tx_out_ready,
    output logic [msix_pkg::BEAT_W-1:0] tx_out_data,
    output logic                        tx_out_last
);

    logic locked;
    logic last_msg;
    logic sel_msg;
    logic out_fire;

    // ====================
    // Grant
    // ====================
    always_comb begin
        if (locked) begin
            sel_msg = 1'b0;
        end else if (pass_valid && msg_valid) begin
            // Both waiting, take turns
            sel_msg = !last_msg;
        end else begin
            sel_msg = msg_valid;
        end
    end

    assign tx_out_valid = sel_msg ? msg_valid : pass_valid;
    assign tx_out_data  = sel_msg ? {msg_data, msg_hdr} : pass_data;
    assign tx_out_last  = sel_msg ? 1'b1 : pass_last;

    assign pass_ready = !sel_msg && tx_out_ready;
    assign msg_ready  = sel_msg && tx_out_ready;

    assign out_fire = tx_out_valid && tx_out_ready;

    // ====================
    // Packet tracking
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            locked   <= 1'b0;
            last_msg <= 1'b0;
        end else if (out_fire) begin
            last_msg <= sel_msg;
            // Hold the function side until its last beat goes out
            locked   <= !sel_msg && !pass_last;
        end
    end

    a_no_interleave: assert property (@(posedge clk) disable iff (!rst_n)
        (out_fire && !sel_msg && !pass_last) |=> !sel_msg);

endmodule

`default_nettype wire
